// ==== compile.f ====
hdl/tm1638_pkg.sv
hdl/sclk_timer.sv
hdl/frame_latch.sv
hdl/digit_encoder.sv
hdl/bus_sequencer.sv
hdl/key_sampler.sv
hdl/tm1638_led_key_drv.sv
tests/tm1638_board_model.sv
tests/tb_tm1638.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the TM1638 driver testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_tm1638 -Mdir "$build_dir" -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_tm1638" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST PASS" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== tests/tb_tm1638.sv ====
module tb_tm1638;
    timeunit 1ns;
    timeprecision 100ps;
    import tm1638_pkg::*;

    localparam int clk_hz       = 1_200_000;
    localparam int sclk_hz      = 300_000;
    localparam int fps          = 1_000;
    localparam int ck_period    = 4;
    // serial half period and frame spacing in system clocks
    localparam int half_len     = (clk_hz + 2 * sclk_hz - 1) / (2 * sclk_hz);
    localparam int frame_cycles = clk_hz / (half_len * fps) * 2 * half_len;
    localparam int n_tests      = 6;
    localparam int watchdog_ns  = n_tests * frame_cycles * ck_period * 3;

    logic                   ck;
    logic                   xarst;
    nibble_t [n_digits-1:0] bin_dat;
    logic [n_digits-1:0]    sup_digits;
    logic [n_digits-1:0]    dots;
    logic [n_digits-1:0]    leds;
    seg_t [n_digits-1:0]    direct_seg;
    logic                   enc_bin;
    logic                   miso;
    logic                   mosi;
    logic                   mosi_oe;
    logic                   sclk;
    logic                   ss;
    key_vec_t               keys;
    key_vec_t               key_pattern;

    // inputs that the checked frame was latched from
    nibble_t [n_digits-1:0] exp_nib;
    logic [n_digits-1:0]    exp_sup;
    logic [n_digits-1:0]    exp_dot;
    logic [n_digits-1:0]    exp_led;
    seg_t [n_digits-1:0]    exp_dseg;
    logic                   exp_enc;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    tm1638_led_key_drv #(
        .clk_hz  (clk_hz),
        .sclk_hz (sclk_hz),
        .fps     (fps)
    ) uut (
        .CK_i             (ck),
        .XARST_i          (xarst),
        .BIN_DAT_i        (bin_dat),
        .SUP_DIGITS_i     (sup_digits),
        .DOTS_i           (dots),
        .LEDS_i           (leds),
        .DIRECT_SEG_i     (direct_seg),
        .ENCBIN_XDIRECT_i (enc_bin),
        .MISO_i           (miso),
        .MOSI_o           (mosi),
        .MOSI_OE_o        (mosi_oe),
        .SCLK_o           (sclk),
        .SS_o             (ss),
        .KEYS_o           (keys)
    );

    tm1638_board_model board (
        .SCLK_i        (sclk),
        .SS_i          (ss),
        .MOSI_i        (mosi),
        .MOSI_OE_i     (mosi_oe),
        .key_pattern_i (key_pattern),
        .MISO_o        (miso)
    );

    initial begin
        ck = 1'b0;
        forever #(ck_period / 2) ck = ~ck;
    end

    initial begin
        #(watchdog_ns);
        $display("run stopped by watchdog after %0d ns, checks: %0d errors: %0d",
                 watchdog_ns, checks, errors);
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input tm_byte_t got, input tm_byte_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_seg(input string name, input seg_t got, input seg_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_keys(input string name, input key_vec_t got, input key_vec_t exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic hold_expected();
        exp_nib  = bin_dat;
        exp_sup  = sup_digits;
        exp_dot  = dots;
        exp_led  = leds;
        exp_dseg = direct_seg;
        exp_enc  = enc_bin;
    endtask

    // returns 1 ns after a clock edge, ready for the next drive
    task automatic wait_frame(input bit at_end);
        int target;
        int cycles;
        target = (at_end ? board.frames_done : board.frames_started) + 1;
        cycles = 0;
        while ((at_end ? board.frames_done : board.frames_started) < target &&
               cycles < 2 * frame_cycles) begin
            @(posedge ck);
            cycles++;
        end
        if ((at_end ? board.frames_done : board.frames_started) < target) begin
            $display("frame %s not seen within %0d clock cycles",
                     at_end ? "end" : "start", 2 * frame_cycles);
            errors++;
        end
        #1;
    endtask

    task automatic check_frame();
        int       exp_len [4];
        int       exp_reads [4];
        seg_t     seg;
        tm_byte_t got;
        exp_len   = '{1, 17, 1, 1};
        exp_reads = '{0, 0, 0, 32};
        checks++;
        if (board.grp_cnt != 4 || board.byte_cnt != 20) begin
            $display("frame had %0d SS groups and %0d written bytes instead of 4 and 20",
                     board.grp_cnt, board.byte_cnt);
            errors++;
            return;
        end
        for (int g = 0; g < 4; g++) begin
            checks++;
            if (board.grp_len[g] != exp_len[g] || board.grp_reads[g] != exp_reads[g]) begin
                $display("SS group %0d wrote %0d bytes and read %0d bits, expected %0d and %0d",
                         g, board.grp_len[g], board.grp_reads[g], exp_len[g], exp_reads[g]);
                errors++;
            end
        end
        check_byte("mode command", board.byte_log[0], 8'h40);
        check_byte("address command", board.byte_log[1], 8'hC0);
        for (int k = 0; k < n_digits; k++) begin
            if (!exp_enc) begin
                seg = exp_dseg[k];
            end else if (exp_sup[k]) begin
                seg = seg_dash;
            end else begin
                seg = hex_to_seg(exp_nib[k]);
            end
            got = board.byte_log[2 + 2 * k];
            check_seg($sformatf("grid %0d segments", k), got[6:0], seg);
            check_byte($sformatf("grid %0d dot", k), {7'd0, got[7]}, {7'd0, exp_dot[k]});
            check_byte($sformatf("led %0d byte", k), board.byte_log[3 + 2 * k],
                       {7'd0, exp_led[k]});
        end
        check_byte("power command", board.byte_log[18], 8'h8F);
        check_byte("key read command", board.byte_log[19], 8'h42);
    endtask

    task automatic test_reset_and_first_frame();
        check_level("SCLK_o", sclk, 1'b1);
        check_level("SS_o", ss, 1'b1);
        check_level("MOSI_o", mosi, 1'b0);
        check_level("MOSI_OE_o", mosi_oe, 1'b0);
        check_keys("KEYS_o", keys, '0);
        hold_expected();
        wait_frame(1'b1);
        check_frame();
        check_keys("KEYS_o", keys, key_pattern);
    endtask

    task automatic test_encode();
        logic [31:0] r;
        rand_bits(32, r);
        bin_dat = r;
        rand_bits(8, r);
        dots = r[7:0];
        rand_bits(8, r);
        leds = r[7:0];
        sup_digits = '0;
        enc_bin    = 1'b1;
        hold_expected();
        wait_frame(1'b1);
        check_frame();
    endtask

    task automatic test_suppress();
        logic [31:0] r;
        rand_bits(8, r);
        // at least one suppressed digit and one shown
        sup_digits    = r[7:0] | 8'h21;
        sup_digits[3] = 1'b0;
        rand_bits(8, r);
        dots = r[7:0];
        hold_expected();
        wait_frame(1'b1);
        check_frame();
    endtask

    task automatic test_direct();
        logic [31:0] r;
        for (int k = 0; k < n_digits; k++) begin
            rand_bits(7, r);
            direct_seg[k] = r[6:0];
        end
        rand_bits(8, r);
        dots    = r[7:0];
        enc_bin = 1'b0;
        hold_expected();
        wait_frame(1'b1);
        check_frame();
    endtask

    task automatic test_key_read();
        logic [31:0] r;
        rand_bits(8, r);
        key_pattern = r[7:0];
        hold_expected();
        wait_frame(1'b1);
        check_frame();
        check_keys("KEYS_o", keys, key_pattern);
    endtask

    task automatic test_frame_stability();
        logic [31:0] r;
        rand_bits(32, r);
        bin_dat = r;
        rand_bits(8, r);
        leds       = r[7:0];
        sup_digits = '0;
        enc_bin    = 1'b1;
        hold_expected();
        wait_frame(1'b0);
        // new inputs while the frame is on the bus
        rand_bits(32, r);
        bin_dat = r;
        rand_bits(8, r);
        leds = r[7:0];
        rand_bits(8, r);
        dots = r[7:0];
        for (int k = 0; k < n_digits; k++) begin
            rand_bits(7, r);
            direct_seg[k] = r[6:0];
        end
        enc_bin = 1'b0;
        wait_frame(1'b1);
        check_frame();
        hold_expected();
        wait_frame(1'b1);
        check_frame();
    endtask

    initial begin
        lfsr_state  = 32'h9c02_bd02;
        errors      = 0;
        checks      = 0;
        xarst       = 1'b0;
        bin_dat     = '0;
        sup_digits  = '0;
        dots        = '0;
        leds        = '0;
        direct_seg  = '0;
        enc_bin     = 1'b1;
        key_pattern = '0;
        repeat (2) @(posedge ck);
        #1;
        xarst = 1'b1;
        test_reset_and_first_frame();
        test_encode();
        test_suppress();
        test_direct();
        test_key_read();
        test_frame_stability();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/tm1638_board_model.sv ====
module tm1638_board_model (
    input  logic                 SCLK_i,
    input  logic                 SS_i,
    input  logic                 MOSI_i,
    input  logic                 MOSI_OE_i,
    input  tm1638_pkg::key_vec_t key_pattern_i,
    output logic                 MISO_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import tm1638_pkg::*;

    localparam int max_bytes = 64;

    // record of the current frame, cleared when the next frame opens
    tm_byte_t byte_log [max_bytes];
    int       grp_len [4]    = '{default: 0};
    int       grp_reads [4]  = '{default: 0};
    int       byte_cnt       = 0;
    int       grp_cnt        = 0;
    int       frames_started = 0;
    int       frames_done    = 0;

    tm_byte_t rx_shift = '0;
    int       rx_bits  = 0;
    int       read_bit = 0;
    logic     in_group = 1'b0;
    logic     reading  = 1'b0;

    initial begin
        MISO_o = 1'b0;
    end

    // read byte r: key 7-2r in bit 0, key 6-2r in bit 4
    function automatic logic key_bit(key_vec_t keys, int pos);
        int         b;
        logic [2:0] lo_key;
        logic [2:0] hi_key;
        b      = pos % 8;
        lo_key = 3'(7 - 2 * (pos / 8));
        hi_key = 3'(6 - 2 * (pos / 8));
        // filler bits carry the inverse of their key
        if (b < 4) begin
            return (b == 0) ? keys[lo_key] : ~keys[lo_key];
        end
        return (b == 4) ? keys[hi_key] : ~keys[hi_key];
    endfunction

    always @(negedge SS_i) begin
        if (grp_cnt == 4) begin
            grp_cnt  = 0;
            byte_cnt = 0;
        end
        if (grp_cnt == 0) begin
            frames_started++;
        end
        grp_len[grp_cnt]   = 0;
        grp_reads[grp_cnt] = 0;
        rx_bits  = 0;
        read_bit = 0;
        reading  = 1'b0;
        in_group = 1'b1;
    end

    always @(posedge SS_i) begin
        if (in_group) begin
            in_group = 1'b0;
            grp_cnt++;
            if (grp_cnt == 4) begin
                frames_done++;
            end
        end
    end

    // bytes arrive lsb first
    always @(posedge SCLK_i) begin
        if (in_group && MOSI_OE_i) begin
            rx_shift = {MOSI_i, rx_shift[7:1]};
            rx_bits++;
            if (rx_bits == 8) begin
                rx_bits = 0;
                if (byte_cnt < max_bytes) begin
                    byte_log[byte_cnt] = rx_shift;
                end
                byte_cnt++;
                grp_len[grp_cnt]++;
                if (rx_shift == cmd_read_keys) begin
                    reading = 1'b1;
                end
            end
        end else if (in_group) begin
            grp_reads[grp_cnt]++;
        end
    end

    // board shifts key data out on the falling clock
    always @(negedge SCLK_i) begin
        if (in_group && reading && read_bit < 32) begin
            MISO_o = key_bit(key_pattern_i, read_bit);
            read_bit++;
        end
    end

endmodule

// ==== hdl/tm1638_led_key_drv.sv ====
module tm1638_led_key_drv #(
    parameter int clk_hz  = 48_000_000,
    parameter int sclk_hz = 1_000,
    parameter int fps     = 250
) (
    input  logic                                           CK_i,
    input  logic                                           XARST_i,
    input  tm1638_pkg::nibble_t [tm1638_pkg::n_digits-1:0] BIN_DAT_i,
    input  logic [tm1638_pkg::n_digits-1:0]                SUP_DIGITS_i,
    input  logic [tm1638_pkg::n_digits-1:0]                DOTS_i,
    input  logic [tm1638_pkg::n_digits-1:0]                LEDS_i,
    input  tm1638_pkg::seg_t [tm1638_pkg::n_digits-1:0]    DIRECT_SEG_i,
    input  logic                                           ENCBIN_XDIRECT_i,
    input  logic                                           MISO_i,
    output logic                                           MOSI_o,
    output logic                                           MOSI_OE_o,
    output logic                                           SCLK_o,
    output logic                                           SS_o,
    output tm1638_pkg::key_vec_t                           KEYS_o
);
    import tm1638_pkg::*;

    logic                     sclk_rise;
    logic                     sclk_fall;
    logic                     frame_req;
    nibble_t [n_digits-1:0]   nib;
    logic [n_digits-1:0]      sup;
    logic [n_digits-1:0]      dot;
    logic [n_digits-1:0]      led;
    seg_t [n_digits-1:0]      dseg;
    logic                     enc_bin;
    tm_byte_t [n_digits-1:0]  digit_data;
    logic                     sample;
    logic [2:0]               key_idx;

    sclk_timer #(
        .clk_hz  (clk_hz),
        .sclk_hz (sclk_hz),
        .fps     (fps)
    ) u_sclk_timer (
        .CK_i        (CK_i),
        .XARST_i     (XARST_i),
        .sclk_rise_o (sclk_rise),
        .sclk_fall_o (sclk_fall),
        .frame_req_o (frame_req)
    );

    frame_latch u_frame_latch (
        .CK_i         (CK_i),
        .XARST_i      (XARST_i),
        .frame_req_i  (frame_req),
        .bin_dat_i    (BIN_DAT_i),
        .sup_digits_i (SUP_DIGITS_i),
        .dots_i       (DOTS_i),
        .leds_i       (LEDS_i),
        .direct_seg_i (DIRECT_SEG_i),
        .enc_bin_i    (ENCBIN_XDIRECT_i),
        .nib_o        (nib),
        .sup_o        (sup),
        .dot_o        (dot),
        .led_o        (led),
        .dseg_o       (dseg),
        .enc_bin_o    (enc_bin)
    );

    for (genvar k = 0; k < n_digits; k++) begin : g_digit
        digit_encoder u_digit_encoder (
            .nib_i     (nib[k]),
            .sup_i     (sup[k]),
            .dseg_i    (dseg[k]),
            .dot_i     (dot[k]),
            .enc_bin_i (enc_bin),
            .data_o    (digit_data[k])
        );
    end

    bus_sequencer u_bus_sequencer (
        .CK_i         (CK_i),
        .XARST_i      (XARST_i),
        .sclk_rise_i  (sclk_rise),
        .sclk_fall_i  (sclk_fall),
        .frame_req_i  (frame_req),
        .digit_data_i (digit_data),
        .led_i        (led),
        .SCLK_o       (SCLK_o),
        .SS_o         (SS_o),
        .MOSI_o       (MOSI_o),
        .MOSI_OE_o    (MOSI_OE_o),
        .sample_o     (sample),
        .key_idx_o    (key_idx)
    );

    key_sampler u_key_sampler (
        .CK_i      (CK_i),
        .XARST_i   (XARST_i),
        .sample_i  (sample),
        .key_idx_i (key_idx),
        .MISO_i    (MISO_i),
        .KEYS_o    (KEYS_o)
    );

endmodule

// ==== hdl/key_sampler.sv ====
module key_sampler (
    input  logic                 CK_i,
    input  logic                 XARST_i,
    input  logic                 sample_i,
    input  logic [2:0]           key_idx_i,
    input  logic                 MISO_i,
    output tm1638_pkg::key_vec_t KEYS_o
);

    // each key updated in place, others hold across frames
    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            KEYS_o <= '0;
        end else if (sample_i) begin
            KEYS_o[key_idx_i] <= MISO_i;
        end
    end

endmodule

// ==== hdl/bus_sequencer.sv ====
module bus_sequencer (
    input  logic                                            CK_i,
    input  logic                                            XARST_i,
    input  logic                                            sclk_rise_i,
    input  logic                                            sclk_fall_i,
    input  logic                                            frame_req_i,
    input  tm1638_pkg::tm_byte_t [tm1638_pkg::n_digits-1:0] digit_data_i,
    input  logic [tm1638_pkg::n_digits-1:0]                 led_i,
    output logic                                            SCLK_o,
    output logic                                            SS_o,
    output logic                                            MOSI_o,
    output logic                                            MOSI_OE_o,
    output logic                                            sample_o,
    output logic [2:0]                                      key_idx_o
);
    import tm1638_pkg::*;

    frame_step_e frame_step;
    byte_state_e byte_state;
    logic [2:0]  bit_cnt;
    logic [3:0]  byte_cnt;
    tm_byte_t    shreg;
    tm_byte_t    next_byte;
    logic        active;
    logic        group_last;

    assign active = (frame_step != step_idle) && (frame_step != step_done);

    // last byte before SS goes back high
    assign group_last = (frame_step == step_set_mode) ||
                        (frame_step == step_set_power) ||
                        (frame_step == step_disp_data && byte_cnt == 4'd15) ||
                        (frame_step == step_key_read && byte_cnt == 4'd3);

    always_comb begin
        case (frame_step)
            step_set_mode:  next_byte = cmd_write_auto;
            step_set_addr:  next_byte = cmd_addr0;
            step_disp_data: begin
                // odd address carries the discrete LED
                if (byte_cnt[0]) begin
                    next_byte = {7'd0, led_i[byte_cnt[3:1]]};
                end else begin
                    next_byte = digit_data_i[byte_cnt[3:1]];
                end
            end
            step_set_power: next_byte = cmd_disp_on_max;
            step_set_read:  next_byte = cmd_read_keys;
            default:        next_byte = '0;
        endcase
    end

    // every step advances on a fall point
    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            frame_step <= step_idle;
            byte_state <= byte_idle;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
        end else if (sclk_fall_i) begin
            case (byte_state)
                byte_idle: begin
                    if (active) begin
                        byte_state <= byte_load;
                    end
                end
                byte_load: begin
                    byte_state <= byte_shift;
                    bit_cnt    <= '0;
                end
                byte_shift: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        byte_state <= byte_finish;
                    end
                end
                default: begin
                    byte_state <= group_last ? byte_idle : byte_load;
                end
            endcase

            case (frame_step)
                step_idle: begin
                    if (frame_req_i) begin
                        frame_step <= step_set_mode;
                    end
                end
                step_done: frame_step <= step_idle;
                default: begin
                    if (byte_state == byte_finish) begin
                        byte_cnt <= '0;
                        case (frame_step)
                            step_set_mode:  frame_step <= step_set_addr;
                            step_set_addr:  frame_step <= step_disp_data;
                            step_set_power: frame_step <= step_set_read;
                            step_set_read:  frame_step <= step_key_read;
                            step_disp_data: begin
                                if (group_last) begin
                                    frame_step <= step_set_power;
                                end else begin
                                    byte_cnt <= byte_cnt + 4'd1;
                                end
                            end
                            default: begin
                                if (group_last) begin
                                    frame_step <= step_done;
                                end else begin
                                    byte_cnt <= byte_cnt + 4'd1;
                                end
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // bus pins, MOSI moves only on fall points
    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            SCLK_o    <= 1'b1;
            SS_o      <= 1'b1;
            MOSI_OE_o <= 1'b0;
            shreg     <= '0;
        end else if (sclk_rise_i) begin
            SCLK_o <= 1'b1;
        end else if (sclk_fall_i) begin
            case (byte_state)
                byte_idle: begin
                    if (active) begin
                        SS_o <= 1'b0;
                    end
                end
                byte_load: begin
                    SCLK_o    <= 1'b0;
                    shreg     <= next_byte;
                    MOSI_OE_o <= (frame_step != step_key_read);
                end
                byte_shift: begin
                    shreg <= {1'b0, shreg[7:1]};
                    if (bit_cnt == 3'd7) begin
                        MOSI_OE_o <= 1'b0;
                    end else begin
                        SCLK_o <= 1'b0;
                    end
                end
                default: begin
                    if (group_last) begin
                        SS_o <= 1'b1;
                    end
                end
            endcase
        end
    end

    assign MOSI_o = shreg[0];

    // key bits sit at positions 0 and 4 of each read byte
    assign sample_o = sclk_rise_i && (frame_step == step_key_read) &&
                      (byte_state == byte_shift) && (bit_cnt[1:0] == 2'b00);
    // read byte r: bit 0 is key 7-2r, bit 4 is key 6-2r
    assign key_idx_o = {~byte_cnt[1:0], ~bit_cnt[2]};

    a_sclk_in_ss: assert property (
        @(posedge CK_i) disable iff (!XARST_i) !SCLK_o |-> !SS_o
    );

    a_no_overrun: assert property (
        @(posedge CK_i) disable iff (!XARST_i) frame_req_i |-> frame_step == step_idle
    );

endmodule

// ==== hdl/digit_encoder.sv ====
module digit_encoder (
    input  tm1638_pkg::nibble_t  nib_i,
    input  logic                 sup_i,
    input  tm1638_pkg::seg_t     dseg_i,
    input  logic                 dot_i,
    input  logic                 enc_bin_i,
    output tm1638_pkg::tm_byte_t data_o
);
    import tm1638_pkg::*;

    seg_t seg;

    always_comb begin
        if (!enc_bin_i) begin
            seg = dseg_i;
        end else if (sup_i) begin
            seg = seg_dash;
        end else begin
            seg = hex_to_seg(nib_i);
        end
    end

    // dot lives in bit 7 of the grid byte
    assign data_o = {dot_i, seg};

endmodule

// ==== hdl/frame_latch.sv ====
module frame_latch (
    input  logic                                           CK_i,
    input  logic                                           XARST_i,
    input  logic                                           frame_req_i,
    input  tm1638_pkg::nibble_t [tm1638_pkg::n_digits-1:0] bin_dat_i,
    input  logic [tm1638_pkg::n_digits-1:0]                sup_digits_i,
    input  logic [tm1638_pkg::n_digits-1:0]                dots_i,
    input  logic [tm1638_pkg::n_digits-1:0]                leds_i,
    input  tm1638_pkg::seg_t [tm1638_pkg::n_digits-1:0]    direct_seg_i,
    input  logic                                           enc_bin_i,
    output tm1638_pkg::nibble_t [tm1638_pkg::n_digits-1:0] nib_o,
    output logic [tm1638_pkg::n_digits-1:0]                sup_o,
    output logic [tm1638_pkg::n_digits-1:0]                dot_o,
    output logic [tm1638_pkg::n_digits-1:0]                led_o,
    output tm1638_pkg::seg_t [tm1638_pkg::n_digits-1:0]    dseg_o,
    output logic                                           enc_bin_o
);

    // mode select, encode after reset
    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            enc_bin_o <= 1'b1;
        end else if (frame_req_i) begin
            enc_bin_o <= enc_bin_i;
        end
    end

    // snapshot held for the whole frame
    always_ff @(posedge CK_i) begin
        if (frame_req_i) begin
            nib_o  <= bin_dat_i;
            sup_o  <= sup_digits_i;
            dot_o  <= dots_i;
            led_o  <= leds_i;
            dseg_o <= direct_seg_i;
        end
    end

endmodule

// ==== hdl/sclk_timer.sv ====
module sclk_timer #(
    parameter int clk_hz  = 48_000_000,
    parameter int sclk_hz = 1_000,
    parameter int fps     = 250
) (
    input  logic CK_i,
    input  logic XARST_i,
    output logic sclk_rise_o,
    output logic sclk_fall_o,
    output logic frame_req_o
);

    // half serial period in system clocks, rounded up
    localparam int half_len = (clk_hz + 2 * sclk_hz - 1) / (2 * sclk_hz);
    localparam int half_w   = (half_len > 1) ? $clog2(half_len) : 1;
    // fall points between frame requests
    localparam int frame_len = clk_hz / (half_len * fps);
    localparam int frame_w   = (frame_len > 1) ? $clog2(frame_len) : 1;

    localparam logic [half_w-1:0]  half_last  = half_w'(half_len - 1);
    localparam logic [frame_w-1:0] frame_last = frame_w'(frame_len - 1);

    logic [half_w-1:0]  div_cnt;
    logic [frame_w-1:0] frame_cnt;
    logic               phase;
    logic               half_tc;
    logic               fall_now;

    assign half_tc  = (div_cnt == half_last);
    assign fall_now = half_tc & ~phase;

    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            div_cnt     <= '0;
            phase       <= 1'b0;
            sclk_rise_o <= 1'b0;
            sclk_fall_o <= 1'b0;
        end else begin
            sclk_rise_o <= half_tc & phase;
            sclk_fall_o <= fall_now;
            if (half_tc) begin
                div_cnt <= '0;
                phase   <= ~phase;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // frame request rides on a fall enable
    always_ff @(posedge CK_i or negedge XARST_i) begin
        if (!XARST_i) begin
            frame_cnt   <= '0;
            frame_req_o <= 1'b0;
        end else begin
            frame_req_o <= fall_now && (frame_cnt == frame_last);
            if (fall_now) begin
                if (frame_cnt == frame_last) begin
                    frame_cnt <= '0;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    a_rise_fall_apart: assert property (
        @(posedge CK_i) disable iff (!XARST_i) !(sclk_rise_o && sclk_fall_o)
    );

endmodule

// ==== hdl/tm1638_pkg.sv ====
package tm1638_pkg;

    // display grids on the board
    localparam int n_digits = 8;

    // segment bits gfedcba
    typedef logic [6:0] seg_t;
    typedef logic [3:0] nibble_t;
    typedef logic [7:0] tm_byte_t;
    typedef logic [7:0] key_vec_t;

    typedef enum logic [7:0] {
        cmd_write_auto  = 8'h40,
        cmd_read_keys   = 8'h42,
        cmd_disp_on_max = 8'h8F,
        cmd_addr0       = 8'hC0
    } tm_cmd_e;

    typedef enum logic [1:0] {
        byte_idle,
        byte_load,
        byte_shift,
        byte_finish
    } byte_state_e;

    typedef enum logic [3:0] {
        step_idle,
        step_set_mode,
        step_set_addr,
        step_disp_data,
        step_set_power,
        step_set_read,
        step_key_read,
        step_done
    } frame_step_e;

    // a suppressed digit shows the middle bar only
    localparam seg_t seg_dash = 7'h40;

    function automatic seg_t hex_to_seg(nibble_t nib);
        case (nib)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'hA: return 7'b1110111;
            4'hB: return 7'b1111100;
            4'hC: return 7'b0111001;
            4'hD: return 7'b1011110;
            4'hE: return 7'b1111001;
            4'hF: return 7'b1110001;
            default: return seg_dash;
        endcase
    endfunction

endpackage
